/* Bender.yml */
package:
  name: datapath_sc

sources:
  - rtl/rv_core_pkg.sv
  - rtl/instr_decoder.sv
  - rtl/register_file.sv
  - rtl/exec_unit.sv
  - rtl/load_store_unit.sv
  - rtl/csr_unit.sv
  - rtl/datapath_sc.sv
  - target: simulation
    files:
      - dv/tb_datapath_sc.sv

/* dv/tb_datapath_sc.sv */
// Testbench for the single-cycle datapath with ROM and data memory models and directed programs
`timescale 1ns/1ps

module tb_datapath_sc import rv_core_pkg::*; ();

	localparam int         TIMEOUT_CYCLES = 5000;
	localparam xlen_t      DONE_ADDR      = 32'h100;
	localparam logic [6:0] OPC_IMM = 7'b0010011;
	localparam logic [6:0] OPC_SYS = 7'b1110011;
	localparam logic [6:0] OPC_LD  = 7'b0000011;

	logic    i_clk, i_rst, i_dm_data_ready;
	xlen_t   o_im_addr, i_im_instr, i_dm_rdata;
	dm_req_t o_dm_req;

	xlen_t   rom [64];
	xlen_t   dmem [128];
	xlen_t   fetch_log [$];
	xlen_t   exp_q [$];
	int      seed = 96;
	int      errors = 0;
	int      checks = 0;
	int      cycles = 0;
	int      emit_at = 0;
	int      wait_cnt = 0;
	logic    zero_delay, done, busy;
	dm_req_t held_req;

	initial begin
		i_clk = 1'b0;
		i_rst = 1'b0;
		i_dm_data_ready = 1'b0;
		i_dm_rdata = '0;
		zero_delay = 1'b1;
		done = 1'b0;
		busy = 1'b0;
	end

	always #5 i_clk = ~i_clk;

	// ROM answers in the same cycle
	assign i_im_instr = rom[o_im_addr[7:2]];

	datapath_sc #(.PC_RESET(32'h0), .HART_ID(32'd3)) datapath_sc_inst (
		.i_clk(i_clk), .i_rst(i_rst), .o_im_addr(o_im_addr), .i_im_instr(i_im_instr),
		.o_dm_req(o_dm_req), .i_dm_data_ready(i_dm_data_ready), .i_dm_rdata(i_dm_rdata)
	);

	function automatic xlen_t itype(input int imm, input int rs1, input int f3, input int rd,
			input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic xlen_t stype(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic xlen_t btype(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic xlen_t jtype(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic xlen_t rtype(input int f7, input int rs2, input int rs1, input int f3,
			input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic xlen_t utype(input logic [19:0] imm, input int rd, input logic [6:0] op);
		return {imm, rd[4:0], op};
	endfunction

	function automatic xlen_t addi(input int rd, input int rs1, input int imm);
		return itype(imm, rs1, 0, rd, OPC_IMM);
	endfunction

	function automatic xlen_t fill_word(input int idx);
		return (idx * 32'h9E37_79B1) ^ 32'hA5A5_A5A5;
	endfunction

	function automatic logic is_misaligned(input dm_req_t req);
		return (req.funct3[1:0] == 2'b01) ? req.addr[0] :
			((req.funct3[1:0] == 2'b10) ? |req.addr[1:0] : 1'b0);
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("MISMATCH at %0t ns: %s", $time, msg);
	endtask

	task automatic check_word(input xlen_t addr, input xlen_t exp, input string what);
		checks++;
		if (dmem[addr[8:2]] !== exp)
			report_mismatch($sformatf("%s at 0x%h: got 0x%h, expected 0x%h",
				what, addr, dmem[addr[8:2]], exp));
	endtask

	// Byte lanes come from the bus already placed by address
	task automatic write_lanes(input dm_req_t req);
		int w;
		w = req.addr[8:2];
		case (req.funct3[1:0])
			2'b00:   dmem[w][req.addr[1:0]*8 +: 8] = req.wdata[req.addr[1:0]*8 +: 8];
			2'b01:   dmem[w][req.addr[1]*16 +: 16] = req.wdata[req.addr[1]*16 +: 16];
			default: dmem[w] = req.wdata;
		endcase
	endtask

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the programs did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Data memory with a random wait before each ready strobe
	always @(posedge i_clk) begin
		if (!i_rst) begin
			i_dm_data_ready <= 1'b0;
			busy <= 1'b0;
		end else if (i_dm_data_ready) begin
			i_dm_data_ready <= 1'b0;
			if (o_dm_req.wen) begin
				write_lanes(o_dm_req);
				if (o_dm_req.addr == DONE_ADDR)
					done <= 1'b1;
			end
		end else if (busy) begin
			if (o_dm_req !== held_req)
				report_mismatch("data request changed while waiting for ready");
			if (wait_cnt == 0) begin
				i_dm_data_ready <= 1'b1;
				i_dm_rdata <= dmem[o_dm_req.addr[8:2]];
				busy <= 1'b0;
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end else if (o_dm_req.wen || o_dm_req.ren) begin
			if (is_misaligned(o_dm_req))
				report_mismatch($sformatf("misaligned access on the bus at 0x%h", o_dm_req.addr));
			busy <= 1'b1;
			held_req <= o_dm_req;
			wait_cnt <= zero_delay ? 0 : {$random(seed)} % 4;
		end
	end

	always @(posedge i_clk) begin
		if (i_rst && ((fetch_log.size() == 0) || (fetch_log[$] != o_im_addr)))
			fetch_log.push_back(o_im_addr);
	end

	task automatic begin_program();
		foreach (rom[i])
			rom[i] = '0;
		emit_at = 0;
		exp_q.delete();
	endtask

	task automatic put(input xlen_t w);
		rom[emit_at] = w;
		emit_at++;
	endtask

	// Result in x3 goes to the next free slot from 0x80
	task automatic result(input xlen_t instr, input xlen_t exp);
		put(instr);
		put(stype(32'h80 + 4 * exp_q.size(), 3, 0, 2));
		exp_q.push_back(exp);
	endtask

	task automatic run_program(input logic no_wait);
		foreach (dmem[i])
			dmem[i] = fill_word(i);
		put(stype(DONE_ADDR, 0, 0, 2));
		zero_delay = no_wait;
		done = 1'b0;
		@(posedge i_clk);
		i_rst <= 1'b0;
		repeat (5) @(posedge i_clk);
		fetch_log.delete();
		i_rst <= 1'b1;
		#1;
		checks++;
		if (o_im_addr !== 32'h0)
			report_mismatch($sformatf("first fetch at 0x%h, expected 0x0", o_im_addr));
		if (o_dm_req.wen || o_dm_req.ren)
			report_mismatch("data request active before any memory instruction");
		while (!done)
			@(posedge i_clk);
		foreach (exp_q[k])
			check_word(32'h80 + 4 * k, exp_q[k], "result");
	endtask

	task automatic arith_ops();
		xlen_t a;
		xlen_t b;
		a = 32'h8765_4321;
		b = 32'hFFFF_FFF9;
		begin_program();
		put(utype(20'h87654, 1, 7'b0110111));
		put(addi(1, 1, 12'h321));
		put(addi(2, 0, -7));
		result(rtype(0, 2, 1, 0, 3), a + b);
		result(rtype(32, 2, 1, 0, 3), a - b);
		result(rtype(0, 2, 1, 1, 3), a << b[4:0]);
		result(rtype(0, 2, 1, 2, 3), {31'b0, $signed(a) < $signed(b)});
		result(rtype(0, 2, 1, 3, 3), {31'b0, a < b});
		result(rtype(0, 2, 1, 4, 3), a ^ b);
		result(rtype(0, 2, 1, 5, 3), a >> b[4:0]);
		result(rtype(32, 2, 1, 5, 3), $signed(a) >>> b[4:0]);
		result(rtype(0, 2, 1, 6, 3), a | b);
		result(rtype(0, 2, 1, 7, 3), a & b);
		result(itype(4, 1, 1, 3, OPC_IMM), a << 4);
		result(itype(12'h403, 1, 5, 3, OPC_IMM), $signed(a) >>> 3);
		result(itype(5, 2, 3, 3, OPC_IMM), 32'd0);
		result(itype(-1, 1, 4, 3, OPC_IMM), ~a);
		result(utype(20'h12345, 3, 7'b0010111), emit_at * 4 + 32'h1234_5000);
		result(utype(20'hFEDCB, 3, 7'b0110111), 32'hFEDC_B000);
		run_program(1'b1);
	endtask

	task automatic control_flow();
		xlen_t seq [15];
		seq = '{32'h00, 32'h04, 32'h08, 32'h0c, 32'h08, 32'h0c, 32'h08, 32'h0c,
			32'h10, 32'h14, 32'h1c, 32'h2c, 32'h20, 32'h24, 32'h28};
		begin_program();
		put(addi(1, 0, 0));
		put(addi(2, 0, 3));
		put(addi(1, 1, 1));
		put(btype(-4, 2, 1, 1));
		put(addi(3, 0, -5));
		put(btype(8, 0, 3, 4));
		put(addi(1, 0, 99));
		put(jtype(16, 5));
		put(stype(32'h80, 1, 0, 2));
		put(stype(32'h84, 5, 0, 2));
		emit_at = 11;
		put(itype(0, 5, 0, 0, 7'b1100111));
		emit_at = 10;
		run_program(1'b1);
		check_word(32'h80, 32'd3, "loop count");
		check_word(32'h84, 32'h20, "JAL link");
		checks++;
		if (fetch_log.size() < 15) begin
			report_mismatch($sformatf("only %0d fetch addresses seen", fetch_log.size()));
		end else begin
			foreach (seq[i])
				if (fetch_log[i] !== seq[i])
					report_mismatch($sformatf("fetch %0d at 0x%h, expected 0x%h",
						i, fetch_log[i], seq[i]));
		end
	endtask

	task automatic loads_stores(input logic no_wait);
		begin_program();
		put(addi(1, 0, 32'h40));
		put(utype(20'hA1B2C, 2, 7'b0110111));
		put(addi(2, 2, 12'h3D4));
		put(stype(0, 2, 1, 2));
		put(stype(5, 2, 1, 0));
		put(stype(10, 2, 1, 1));
		result(itype(0, 1, 0, 3, OPC_LD), 32'hFFFF_FFD4);
		result(itype(0, 1, 4, 3, OPC_LD), 32'h0000_00D4);
		result(itype(2, 1, 1, 3, OPC_LD), 32'hFFFF_A1B2);
		result(itype(2, 1, 5, 3, OPC_LD), 32'h0000_A1B2);
		result(itype(0, 1, 2, 3, OPC_LD), 32'hA1B2_C3D4);
		result(itype(3, 1, 0, 3, OPC_LD), 32'hFFFF_FFA1);
		result(itype(5, 1, 4, 3, OPC_LD), 32'h0000_00D4);
		result(itype(10, 1, 1, 3, OPC_LD), 32'hFFFF_C3D4);
		run_program(no_wait);
		check_word(32'h44, (fill_word(17) & 32'hFFFF_00FF) | 32'h0000_D400, "byte store");
		check_word(32'h48, (fill_word(18) & 32'h0000_FFFF) | 32'hC3D4_0000, "half store");
	endtask

	task automatic trap_entry();
		begin_program();
		put(addi(10, 0, 32'h80));
		put(addi(1, 0, 32'h40));
		put(itype(CSR_MTVEC, 1, 1, 0, OPC_SYS));
		put(32'h0000_0073);
		put(addi(2, 0, 7));
		put(stype(3, 2, 0, 2));
		put(32'h0000_0000);
		put(stype(32'hF0, 2, 0, 2));
		emit_at = 16;
		// Handler logs mcause, mepc and mtval, then skips the trapping word
		put(itype(CSR_MCAUSE, 0, 2, 3, OPC_SYS));
		put(itype(CSR_MEPC, 0, 2, 4, OPC_SYS));
		put(itype(CSR_MTVAL, 0, 2, 5, OPC_SYS));
		put(stype(0, 3, 10, 2));
		put(stype(4, 4, 10, 2));
		put(stype(8, 5, 10, 2));
		put(addi(10, 10, 12));
		put(addi(4, 4, 4));
		put(itype(CSR_MEPC, 4, 1, 0, OPC_SYS));
		put(32'h3020_0073);
		emit_at = 8;
		run_program(1'b0);
		check_word(32'h80, 32'd11, "ECALL mcause");
		check_word(32'h84, 32'h0c, "ECALL mepc");
		check_word(32'h8c, 32'd6, "store misaligned mcause");
		check_word(32'h90, 32'h14, "store misaligned mepc");
		check_word(32'h94, 32'h03, "store misaligned address");
		check_word(32'h98, 32'd2, "illegal mcause");
		check_word(32'h9c, 32'h18, "illegal mepc");
		check_word(32'hF0, 32'd7, "resume after MRET");
	endtask

	task automatic csr_access();
		begin_program();
		result(itype(CSR_MHARTID, 0, 2, 3, OPC_SYS), 32'd3);
		put(addi(2, 0, 32'h5a));
		result(itype(CSR_MSCRATCH, 2, 1, 3, OPC_SYS), 32'h0);
		result(itype(CSR_MSCRATCH, 5, 6, 3, OPC_SYS), 32'h5a);
		result(itype(CSR_MSCRATCH, 3, 7, 3, OPC_SYS), 32'h5a | 32'h5);
		result(itype(CSR_MSCRATCH, 0, 2, 3, OPC_SYS), (32'h5a | 32'h5) & ~32'h3);
		run_program(1'b0);
	endtask

	initial begin
		arith_ops();
		control_flow();
		loads_stores(1'b1);
		loads_stores(1'b0);
		trap_entry();
		csr_access();
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* rtl/csr_unit.sv */
// Machine-mode CSR block with trap entry, MRET and the PC redirect target
`timescale 1ns/1ps

module csr_unit import rv_core_pkg::*; #(
	parameter xlen_t HART_ID = '0
) (
	input  logic  i_clk,
	input  logic  i_rst,
	input  ctrl_t i_ctrl,
	input  xlen_t i_instr,
	input  xlen_t i_wdata,
	input  xlen_t i_pc,
	input  xlen_t i_badaddr,
	input  logic  i_ex_instr_addr,
	input  logic  i_ex_load,
	input  logic  i_ex_store,
	input  logic  i_stall,
	output xlen_t o_csr_rdata,
	output logic  o_trap,
	output logic  o_eret,
	output xlen_t o_redirect_pc
);

	xlen_t     mtvec_q, mepc_q, mcause_q, mscratch_q, mtval_q;
	csr_addr_t csr_addr;
	funct3_t   funct3;
	logic      csr_known;
	logic      csr_write;
	logic      illegal;
	xlen_t     csr_new;
	xlen_t     cause;

	assign csr_addr = i_instr[31:20];
	assign funct3   = i_instr[14:12];

	always_comb begin
		csr_known = 1'b1;
		case (csr_addr)
			CSR_MSCRATCH: o_csr_rdata = mscratch_q;
			CSR_MTVEC:    o_csr_rdata = mtvec_q;
			CSR_MEPC:     o_csr_rdata = mepc_q;
			CSR_MCAUSE:   o_csr_rdata = mcause_q;
			CSR_MTVAL:    o_csr_rdata = mtval_q;
			CSR_MHARTID:  o_csr_rdata = HART_ID;
			default: begin
				csr_known   = 1'b0;
				o_csr_rdata = '0;
			end
		endcase
	end

	// Set and clear with rs1 = x0 only read
	assign csr_write = i_ctrl.csr_en && ((funct3[1:0] == 2'b01) || (i_instr[19:15] != '0));

	always_comb begin
		case (funct3[1:0])
			2'b10:   csr_new = o_csr_rdata | i_wdata;
			2'b11:   csr_new = o_csr_rdata & ~i_wdata;
			default: csr_new = i_wdata;
		endcase
	end

	assign illegal = i_ctrl.illegal || (i_ctrl.csr_en &&
		(!csr_known || (csr_write && (csr_addr == CSR_MHARTID))));
	assign o_trap  = illegal || i_ctrl.ecall || i_ex_instr_addr || i_ex_load || i_ex_store;
	assign o_eret  = i_ctrl.mret;

	always_comb begin
		if (illegal)
			cause = CAUSE_ILLEGAL;
		else if (i_ctrl.ecall)
			cause = CAUSE_ECALL_M;
		else if (i_ex_instr_addr)
			cause = CAUSE_INSTR_MISALIGNED;
		else if (i_ex_load)
			cause = CAUSE_LOAD_MISALIGNED;
		else
			cause = CAUSE_STORE_MISALIGNED;
	end

	assign o_redirect_pc = o_trap ? {mtvec_q[31:2], 2'b00} : mepc_q;

	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			mtvec_q    <= '0;
			mepc_q     <= '0;
			mcause_q   <= '0;
			mscratch_q <= '0;
			mtval_q    <= '0;
		end else if (!i_stall) begin
			if (o_trap) begin
				mepc_q   <= i_pc;
				mcause_q <= cause;
				// Only address faults carry a meaningful value
				mtval_q  <= (illegal || i_ctrl.ecall) ? '0 : i_badaddr;
			end else if (csr_write) begin
				case (csr_addr)
					CSR_MSCRATCH: mscratch_q <= csr_new;
					CSR_MTVEC:    mtvec_q    <= csr_new;
					CSR_MEPC:     mepc_q     <= csr_new;
					CSR_MCAUSE:   mcause_q   <= csr_new;
					CSR_MTVAL:    mtval_q    <= csr_new;
					default: ;
				endcase
			end
		end
	end

	trap_eret_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst)
		!(o_trap && o_eret))
	else $error("trap and MRET raised in the same cycle");

endmodule

/* rtl/datapath_sc.sv */
// Single-cycle RV32I datapath with PC, operand muxes, next-PC logic and write-back
`timescale 1ns/1ps

module datapath_sc import rv_core_pkg::*; #(
	parameter xlen_t PC_RESET = '0,
	parameter xlen_t HART_ID  = '0
) (
	input  logic    i_clk,
	input  logic    i_rst,
	output xlen_t   o_im_addr,
	input  xlen_t   i_im_instr,
	output dm_req_t o_dm_req,
	input  logic    i_dm_data_ready,
	input  xlen_t   i_dm_rdata
);

	xlen_t   pc_q;
	xlen_t   pc_plus4;
	xlen_t   seq_pc;
	xlen_t   next_pc;
	ctrl_t   ctrl;
	xlen_t   imm;
	xlen_t   rs1_data, rs2_data;
	xlen_t   op_a, op_b;
	xlen_t   alu_result;
	logic    take_branch;
	xlen_t   load_data;
	xlen_t   csr_rdata;
	xlen_t   redirect_pc;
	xlen_t   badaddr;
	xlen_t   wb_data;
	logic    stall, trap, eret;
	logic    ex_instr_addr, ex_load, ex_store;

	assign o_im_addr = pc_q;
	assign pc_plus4  = pc_q + 32'd4;

	always_ff @(posedge i_clk) begin
		if (!i_rst)
			pc_q <= PC_RESET;
		else if (!stall)
			pc_q <= next_pc;
	end

	instr_decoder instr_decoder_inst (
		.i_instr (i_im_instr),
		.o_ctrl  (ctrl),
		.o_imm   (imm)
	);

	register_file register_file_inst (
		.i_clk      (i_clk),
		.i_rs1      (i_im_instr[19:15]),
		.i_rs2      (i_im_instr[24:20]),
		.i_rd       (i_im_instr[11:7]),
		.i_wen      (ctrl.reg_write && !trap && !stall),
		.i_wdata    (wb_data),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	assign op_a = ctrl.src_a_zero ? '0 : (ctrl.src_a_pc ? pc_q : rs1_data);
	assign op_b = ctrl.src_b_imm ? imm : rs2_data;

	exec_unit exec_unit_inst (
		.i_a           (op_a),
		.i_b           (op_b),
		.i_alu_op      (ctrl.alu_op),
		.i_branch      (ctrl.branch),
		.i_funct3      (i_im_instr[14:12]),
		.o_result      (alu_result),
		.o_take_branch (take_branch)
	);

	load_store_unit load_store_unit_inst (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_ctrl          (ctrl),
		.i_addr          (alu_result),
		.i_store_data    (rs2_data),
		.i_funct3        (i_im_instr[14:12]),
		.i_trap          (trap),
		.o_dm_req        (o_dm_req),
		.i_dm_data_ready (i_dm_data_ready),
		.i_dm_rdata      (i_dm_rdata),
		.o_load_data     (load_data),
		.o_stall         (stall),
		.o_ex_load       (ex_load),
		.o_ex_store      (ex_store)
	);

	// Sequential target before any trap or MRET redirect
	always_comb begin
		if (ctrl.jump == JUMP_JALR)
			seq_pc = alu_result & ~32'd1;
		else if ((ctrl.jump == JUMP_JAL) || take_branch)
			seq_pc = pc_q + imm;
		else
			seq_pc = pc_plus4;
	end

	assign ex_instr_addr = |seq_pc[1:0];
	assign badaddr       = (ex_load || ex_store) ? alu_result : seq_pc;

	csr_unit #(
		.HART_ID (HART_ID)
	) csr_unit_inst (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_ctrl          (ctrl),
		.i_instr         (i_im_instr),
		.i_wdata         (alu_result),
		.i_pc            (pc_q),
		.i_badaddr       (badaddr),
		.i_ex_instr_addr (ex_instr_addr),
		.i_ex_load       (ex_load),
		.i_ex_store      (ex_store),
		.i_stall         (stall),
		.o_csr_rdata     (csr_rdata),
		.o_trap          (trap),
		.o_eret          (eret),
		.o_redirect_pc   (redirect_pc)
	);

	assign next_pc = (trap || eret) ? redirect_pc : seq_pc;

	always_comb begin
		case (ctrl.wb_sel)
			WB_MEM:  wb_data = load_data;
			WB_PC4:  wb_data = pc_plus4;
			WB_CSR:  wb_data = csr_rdata;
			default: wb_data = alu_result;
		endcase
	end

endmodule

/* rtl/exec_unit.sv */
// Execute unit with the ALU and the branch condition check
`timescale 1ns/1ps

module exec_unit import rv_core_pkg::*; (
	input  xlen_t   i_a,
	input  xlen_t   i_b,
	input  alu_op_e i_alu_op,
	input  logic    i_branch,
	input  funct3_t i_funct3,
	output xlen_t   o_result,
	output logic    o_take_branch
);

	logic [32:0] diff_ext;
	xlen_t       diff;
	logic        eq;
	logic        lt_s;
	logic        lt_u;
	logic        cond;

	// One subtractor serves SUB, SLT, SLTU and every branch compare
	assign diff_ext = {1'b0, i_a} - {1'b0, i_b};
	assign diff     = diff_ext[31:0];
	assign eq       = (diff == '0);
	assign lt_u     = diff_ext[32];
	assign lt_s     = (i_a[31] != i_b[31]) ? i_a[31] : diff[31];

	always_comb begin
		case (i_alu_op)
			ALU_ADD:    o_result = i_a + i_b;
			ALU_SUB:    o_result = diff;
			ALU_SLL:    o_result = i_a << i_b[4:0];
			ALU_SLT:    o_result = {31'b0, lt_s};
			ALU_SLTU:   o_result = {31'b0, lt_u};
			ALU_XOR:    o_result = i_a ^ i_b;
			ALU_SRL:    o_result = i_a >> i_b[4:0];
			ALU_SRA:    o_result = $signed(i_a) >>> i_b[4:0];
			ALU_OR:     o_result = i_a | i_b;
			ALU_AND:    o_result = i_a & i_b;
			ALU_PASS_B: o_result = i_b;
			default:    o_result = '0;
		endcase
	end

	always_comb begin
		case (i_funct3)
			3'b000:  cond = eq;
			3'b001:  cond = !eq;
			3'b100:  cond = lt_s;
			3'b101:  cond = !lt_s;
			3'b110:  cond = lt_u;
			3'b111:  cond = !lt_u;
			default: cond = 1'b0;
		endcase
	end

	assign o_take_branch = i_branch && cond;

endmodule

/* rtl/instr_decoder.sv */
// Instruction decoder that builds the control bundle and the immediate for RV32I
`timescale 1ns/1ps

module instr_decoder import rv_core_pkg::*; (
	input  xlen_t i_instr,
	output ctrl_t o_ctrl,
	output xlen_t o_imm
);

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_FENCE  = 7'b0001111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	logic [6:0] opcode;
	funct3_t    funct3;
	logic [6:0] funct7;
	logic       illegal;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];

	// Shared between OP and OP-IMM, alt picks SUB or SRA
	function automatic alu_op_e alu_from_funct3(input funct3_t f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		o_ctrl = '{alu_op: ALU_ADD, wb_sel: WB_ALU, jump: JUMP_NONE, default: '0};
		illegal = 1'b0;
		case (opcode)
			OP_LUI: begin
				o_ctrl.src_a_zero = 1'b1;
				o_ctrl.src_b_imm  = 1'b1;
				o_ctrl.reg_write  = 1'b1;
			end
			OP_AUIPC: begin
				o_ctrl.src_a_pc  = 1'b1;
				o_ctrl.src_b_imm = 1'b1;
				o_ctrl.reg_write = 1'b1;
			end
			OP_JAL: begin
				o_ctrl.jump      = JUMP_JAL;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.wb_sel    = WB_PC4;
			end
			OP_JALR: begin
				o_ctrl.jump      = JUMP_JALR;
				o_ctrl.src_b_imm = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.wb_sel    = WB_PC4;
				illegal = (funct3 != 3'b000);
			end
			OP_BRANCH: begin
				// Compare on rs1 and rs2, target computed at the top
				o_ctrl.branch = 1'b1;
				o_ctrl.alu_op = ALU_SUB;
				illegal = (funct3[2:1] == 2'b01);
			end
			OP_LOAD: begin
				o_ctrl.src_b_imm = 1'b1;
				o_ctrl.mem_read  = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.wb_sel    = WB_MEM;
				illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
			end
			OP_STORE: begin
				o_ctrl.src_b_imm = 1'b1;
				o_ctrl.mem_write = 1'b1;
				illegal = funct3[2] || (funct3[1:0] == 2'b11);
			end
			OP_IMM: begin
				o_ctrl.src_b_imm = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.alu_op = alu_from_funct3(funct3, funct7[5] && (funct3 == 3'b101));
				if (funct3 == 3'b001)
					illegal = (funct7 != 7'b0000000);
				else if (funct3 == 3'b101)
					illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
			end
			OP_REG: begin
				o_ctrl.reg_write = 1'b1;
				o_ctrl.alu_op = alu_from_funct3(funct3, funct7[5]);
				if (funct7 == 7'b0100000)
					illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
				else
					illegal = (funct7 != 7'b0000000);
			end
			OP_FENCE: begin
				// Single hart with in-order memory, nothing to order
			end
			OP_SYSTEM: begin
				if (funct3 == 3'b000) begin
					o_ctrl.ecall = (i_instr == 32'h0000_0073);
					o_ctrl.mret  = (i_instr == 32'h3020_0073);
					illegal = !o_ctrl.ecall && !o_ctrl.mret;
				end else if (funct3 == 3'b100) begin
					illegal = 1'b1;
				end else begin
					// CSR operand through the ALU, rs1 + 0 or the zimm
					o_ctrl.csr_en    = 1'b1;
					o_ctrl.reg_write = 1'b1;
					o_ctrl.wb_sel    = WB_CSR;
					o_ctrl.src_b_imm = 1'b1;
					o_ctrl.alu_op    = funct3[2] ? ALU_PASS_B : ALU_ADD;
				end
			end
			default: illegal = 1'b1;
		endcase
		o_ctrl.illegal = illegal;
		if (illegal) begin
			o_ctrl.reg_write = 1'b0;
			o_ctrl.mem_read  = 1'b0;
			o_ctrl.mem_write = 1'b0;
			o_ctrl.csr_en    = 1'b0;
		end
	end

	always_comb begin
		case (opcode)
			OP_LUI, OP_AUIPC: o_imm = {i_instr[31:12], 12'b0};
			OP_JAL:    o_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
				i_instr[30:21], 1'b0};
			OP_BRANCH: o_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
				i_instr[11:8], 1'b0};
			OP_STORE:  o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
			OP_SYSTEM: o_imm = funct3[2] ? {27'b0, i_instr[19:15]} : '0;
			default:   o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
		endcase
	end

endmodule

/* rtl/load_store_unit.sv */
// Load/store unit for alignment checks, lane placement, load extension and stalls
`timescale 1ns/1ps

module load_store_unit import rv_core_pkg::*; (
	input  logic    i_clk,
	input  logic    i_rst,
	input  ctrl_t   i_ctrl,
	input  xlen_t   i_addr,
	input  xlen_t   i_store_data,
	input  funct3_t i_funct3,
	input  logic    i_trap,
	output dm_req_t o_dm_req,
	input  logic    i_dm_data_ready,
	input  xlen_t   i_dm_rdata,
	output xlen_t   o_load_data,
	output logic    o_stall,
	output logic    o_ex_load,
	output logic    o_ex_store
);

	logic       misaligned;
	logic [4:0] lane_shift;
	xlen_t      lane_data;

	// Size comes from funct3[1:0], size 3 never reaches here legally
	always_comb begin
		case (i_funct3[1:0])
			2'b00:   misaligned = 1'b0;
			2'b01:   misaligned = i_addr[0];
			2'b10:   misaligned = |i_addr[1:0];
			default: misaligned = 1'b1;
		endcase
	end

	assign o_ex_load  = i_ctrl.mem_read && misaligned;
	assign o_ex_store = i_ctrl.mem_write && misaligned;

	assign lane_shift = {i_addr[1:0], 3'b000};

	assign o_dm_req.addr   = i_addr;
	assign o_dm_req.funct3 = i_funct3;
	assign o_dm_req.wen    = i_ctrl.mem_write && !misaligned && !i_trap;
	assign o_dm_req.ren    = i_ctrl.mem_read && !misaligned && !i_trap;

	always_comb begin
		case (i_funct3[1:0])
			2'b00:   o_dm_req.wdata = {24'b0, i_store_data[7:0]} << lane_shift;
			2'b01:   o_dm_req.wdata = {16'b0, i_store_data[15:0]} << lane_shift;
			default: o_dm_req.wdata = i_store_data;
		endcase
	end

	// Addressed lane moved down to bit 0 before extension
	assign lane_data = i_dm_rdata >> lane_shift;

	always_comb begin
		case (i_funct3)
			3'b000:  o_load_data = {{24{lane_data[7]}}, lane_data[7:0]};
			3'b001:  o_load_data = {{16{lane_data[15]}}, lane_data[15:0]};
			3'b100:  o_load_data = {24'b0, lane_data[7:0]};
			3'b101:  o_load_data = {16'b0, lane_data[15:0]};
			default: o_load_data = i_dm_rdata;
		endcase
	end

	assign o_stall = (o_dm_req.wen || o_dm_req.ren) && !i_dm_data_ready;

	req_held_until_ready: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_stall |=> $stable(o_dm_req))
	else $error("data request changed before data ready");

endmodule

/* rtl/register_file.sv */
// Register file with 32 general registers, two read ports and one write port
`timescale 1ns/1ps

module register_file import rv_core_pkg::*; (
	input  logic     i_clk,
	input  reg_idx_t i_rs1,
	input  reg_idx_t i_rs2,
	input  reg_idx_t i_rd,
	input  logic     i_wen,
	input  xlen_t    i_wdata,
	output xlen_t    o_rs1_data,
	output xlen_t    o_rs2_data
);

	xlen_t regs [32];

	// Entry 0 is never written, reads of x0 are forced to zero
	always_ff @(posedge i_clk) begin
		if (i_wen && (i_rd != '0)) begin
			regs[i_rd] <= i_wdata;
		end
	end

	assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

	x0_reads_zero: assert property (@(posedge i_clk)
		((i_rs1 == '0) |-> (o_rs1_data == '0)) and ((i_rs2 == '0) |-> (o_rs2_data == '0)))
	else $error("x0 read returned a nonzero value");

endmodule

/* rtl/rv_core_pkg.sv */
// Core package with the shared widths, control bundle, memory request and CSR constants
package rv_core_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [11:0] csr_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4,
		WB_CSR
	} wb_sel_e;

	typedef enum logic [1:0] {
		JUMP_NONE,
		JUMP_JAL,
		JUMP_JALR
	} jump_e;

	// Decoder output, one bundle per instruction
	typedef struct packed {
		alu_op_e alu_op;
		logic    src_a_pc;
		logic    src_a_zero;
		logic    src_b_imm;
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		wb_sel_e wb_sel;
		jump_e   jump;
		logic    branch;
		logic    csr_en;
		logic    ecall;
		logic    mret;
		logic    illegal;
	} ctrl_t;

	// Data memory request, levels held until data ready
	typedef struct packed {
		xlen_t   addr;
		xlen_t   wdata;
		funct3_t funct3;
		logic    wen;
		logic    ren;
	} dm_req_t;

	localparam xlen_t CAUSE_INSTR_MISALIGNED = 32'd0;
	localparam xlen_t CAUSE_ILLEGAL          = 32'd2;
	localparam xlen_t CAUSE_LOAD_MISALIGNED  = 32'd4;
	localparam xlen_t CAUSE_STORE_MISALIGNED = 32'd6;
	localparam xlen_t CAUSE_ECALL_M          = 32'd11;

	localparam csr_addr_t CSR_MSCRATCH = 12'h340;
	localparam csr_addr_t CSR_MTVEC    = 12'h305;
	localparam csr_addr_t CSR_MEPC     = 12'h341;
	localparam csr_addr_t CSR_MCAUSE   = 12'h342;
	localparam csr_addr_t CSR_MTVAL    = 12'h343;
	localparam csr_addr_t CSR_MHARTID  = 12'hF14;

endpackage

/* sim.f */
rtl/rv_core_pkg.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/exec_unit.sv
rtl/load_store_unit.sv
rtl/csr_unit.sv
rtl/datapath_sc.sv
dv/tb_datapath_sc.sv
